/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb_obi_mem
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+src
src/obi_mem_pkg.sv
src/obi_req_checker.sv
src/obi_mem_array.sv
src/obi_rsp_encoder.sv
src/obi_mem_top.sv
sim/obi_mem_checker.sv
sim/tb_obi_mem.sv

/* sim/obi_mem_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "obi_mem_config.svh"

module obi_mem_checker (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        req_i,
    input  logic                        reqpar_i,
    input  obi_mem_pkg::obi_req_t       req_pld_i,
    input  logic                        gnt_o,
    input  logic                        gntpar_o,
    input  logic                        rvalid_o,
    input  logic                        rvalidpar_o,
    input  logic [`OBI_DATA_WIDTH-1:0]  rdata_o,
    input  logic                        err_o,
    input  logic [`OBI_RCHK_WIDTH-1:0]  rchk_o,
    input  logic                        alert_major_o,
    input  logic                        alert_minor_o,
    output int                          proto_errs_o,
    output int                          data_errs_o,
    output int                          alert_errs_o,
    output int                          pending_o
);

    // One outstanding response as the model expects it
    typedef struct packed {
        int                                due;
        obi_mem_pkg::rsp_kind_e            kind;
        logic [`OBI_DATA_WIDTH-1:0]        rdata;
        logic [obi_mem_pkg::BE_WIDTH-1:0]  mask;
    } exp_rsp_t;

    exp_rsp_t                         exp_q[$];
    exp_rsp_t                         head;
    logic [`OBI_DATA_WIDTH-1:0]       mem_model [`OBI_MEM_WORDS];
    // Bytes that hold a known value
    logic [obi_mem_pkg::BE_WIDTH-1:0] written [`OBI_MEM_WORDS];
    int                               cycle;
    logic                             gnt_exp;
    logic                             major_exp;
    int                               proto_errs = 0;
    int                               data_errs = 0;
    int                               alert_errs = 0;

    // Check bits rebuilt bit by bit from the request fields
    function automatic logic [`OBI_ACHK_WIDTH-1:0] expected_achk(input obi_mem_pkg::obi_req_t r);
        logic [`OBI_ACHK_WIDTH-1:0] c;
        c = '0;
        for (int b = 0; b < `OBI_DATA_WIDTH; b++) begin
            c[b/8]     = c[b/8] ^ r.addr[b];
            c[4 + b/8] = c[4 + b/8] ^ r.wdata[b];
        end
        c[8] = r.we ^ r.be[0] ^ r.be[1] ^ r.be[2] ^ r.be[3];
        return c;
    endfunction

    // --------------------------------------------------
    // Per-cycle port rules
    // --------------------------------------------------
    task automatic check_ports();
        logic [`OBI_RCHK_WIDTH-1:0] rchk_exp;
        if (gnt_o !== gnt_exp || gntpar_o !== ~gnt_o) begin
            proto_errs++;
            $display("error at %0t: gnt %b gntpar %b, gnt expected %b", $time, gnt_o, gntpar_o,
                     gnt_exp);
        end
        if (rvalidpar_o !== ~rvalid_o) begin
            proto_errs++;
            $display("error at %0t: rvalidpar %b next to rvalid %b", $time, rvalidpar_o, rvalid_o);
        end
        if (alert_major_o !== major_exp) begin
            alert_errs++;
            $display("error at %0t: major alert %b, expected %b", $time, alert_major_o, major_exp);
        end
        for (int i = 0; i < obi_mem_pkg::BE_WIDTH; i++) begin
            rchk_exp[i] = ^rdata_o[8*i +: 8];
        end
        rchk_exp[`OBI_RCHK_WIDTH-1] = err_o;
        if (rchk_o !== rchk_exp) begin
            data_errs++;
            $display("error at %0t: rchk %h, expected %h", $time, rchk_o, rchk_exp);
        end
    endtask

    // --------------------------------------------------
    // Response against the head of the queue
    // --------------------------------------------------
    task automatic check_response();
        if (rvalid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("error at %0t: response with no request in flight", $time);
            end else begin
                head = exp_q.pop_front();
                if (head.due != cycle) begin
                    proto_errs++;
                    $display("error at %0t: response %0d cycles late", $time, cycle - head.due);
                end
                if (err_o !== (head.kind != obi_mem_pkg::RSP_OK)) begin
                    data_errs++;
                    $display("error at %0t: err %b for kind %s", $time, err_o, head.kind.name());
                end
                // Unknown bytes of a read are left unchecked
                for (int b = 0; b < obi_mem_pkg::BE_WIDTH; b++) begin
                    if (head.mask[b] && rdata_o[8*b +: 8] !== head.rdata[8*b +: 8]) begin
                        data_errs++;
                        $display("error at %0t: rdata byte %0d is %h, expected %h", $time, b,
                                 rdata_o[8*b +: 8], head.rdata[8*b +: 8]);
                    end
                end
                if (alert_minor_o !== (head.kind == obi_mem_pkg::RSP_RANGE_FAULT)) begin
                    alert_errs++;
                    $display("error at %0t: minor alert %b for kind %s", $time, alert_minor_o,
                             head.kind.name());
                end
            end
        end else begin
            if (alert_minor_o !== 1'b0) begin
                alert_errs++;
                $display("error at %0t: minor alert without a response", $time);
            end
            if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                proto_errs++;
                $display("error at %0t: response missing for an accepted request", $time);
                head = exp_q.pop_front();
            end
        end
    endtask

    // --------------------------------------------------
    // Request model
    // --------------------------------------------------
    task automatic model_request();
        exp_rsp_t                                item;
        logic [obi_mem_pkg::WORD_IDX_WIDTH-1:0]  idx;
        logic                                    achk_bad;
        achk_bad = (expected_achk(req_pld_i) != req_pld_i.achk);
        if (req_i && gnt_exp) begin
            idx        = req_pld_i.addr[obi_mem_pkg::WORD_IDX_WIDTH+1:2];
            item.due   = cycle + 2;
            item.rdata = '0;
            item.mask  = '1;
            if (achk_bad) begin
                item.kind = obi_mem_pkg::RSP_ACHK_FAULT;
            end else if (req_pld_i.addr >= `OBI_MEM_WORDS * 4) begin
                item.kind = obi_mem_pkg::RSP_RANGE_FAULT;
            end else begin
                item.kind = obi_mem_pkg::RSP_OK;
                if (req_pld_i.we) begin
                    // Merge only the enabled bytes
                    for (int b = 0; b < obi_mem_pkg::BE_WIDTH; b++) begin
                        if (req_pld_i.be[b]) begin
                            mem_model[idx][8*b +: 8] = req_pld_i.wdata[8*b +: 8];
                        end
                    end
                    written[idx] = written[idx] | req_pld_i.be;
                end else begin
                    item.rdata = mem_model[idx];
                    item.mask  = written[idx];
                end
            end
            exp_q.push_back(item);
        end
        if ((reqpar_i == req_i) || (req_i && gnt_exp && achk_bad)) begin
            major_exp = 1'b1;
        end
        gnt_exp = 1'b1;
    endtask

    always @(posedge clk_i) begin
        if (reset_i) begin
            gnt_exp   = 1'b0;
            major_exp = 1'b0;
            cycle     = 0;
            exp_q.delete();
            for (int w = 0; w < `OBI_MEM_WORDS; w++) begin
                written[w] = '0;
            end
        end else begin
            cycle++;
            check_ports();
            check_response();
            model_request();
        end
        pending_o = exp_q.size();
    end

    assign proto_errs_o = proto_errs;
    assign data_errs_o  = data_errs;
    assign alert_errs_o = alert_errs;

endmodule

`default_nettype wire

/* sim/tb_obi_mem.sv */
`timescale 1ns/10ps
`default_nettype none
`include "obi_mem_config.svh"

module tb_obi_mem;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_CLEAN    = 600;
    localparam int NUM_CORRUPT  = 40;
    // One clock per request slot, plus drain and margin
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CLEAN + NUM_CORRUPT) * CLK_PERIOD + 500;

    logic                        clk;
    logic                        reset_i;
    logic                        req_i;
    logic                        reqpar_i;
    obi_mem_pkg::obi_req_t       req_pld_i;
    logic                        gnt_o;
    logic                        gntpar_o;
    logic                        rvalid_o;
    logic                        rvalidpar_o;
    logic [`OBI_DATA_WIDTH-1:0]  rdata_o;
    logic                        err_o;
    logic [`OBI_RCHK_WIDTH-1:0]  rchk_o;
    logic                        alert_major_o;
    logic                        alert_minor_o;
    int                          proto_errs;
    int                          data_errs;
    int                          alert_errs;
    int                          pending;
    integer                      seed;

    obi_mem_top i_dut (
        .clk_i (clk), .reset_i (reset_i), .req_i (req_i), .reqpar_i (reqpar_i),
        .req_pld_i (req_pld_i), .gnt_o (gnt_o), .gntpar_o (gntpar_o), .rvalid_o (rvalid_o),
        .rvalidpar_o (rvalidpar_o), .rdata_o (rdata_o), .err_o (err_o), .rchk_o (rchk_o),
        .alert_major_o (alert_major_o), .alert_minor_o (alert_minor_o)
    );

    obi_mem_checker i_checker (
        .clk_i (clk), .reset_i (reset_i), .req_i (req_i), .reqpar_i (reqpar_i),
        .req_pld_i (req_pld_i), .gnt_o (gnt_o), .gntpar_o (gntpar_o), .rvalid_o (rvalid_o),
        .rvalidpar_o (rvalidpar_o), .rdata_o (rdata_o), .err_o (err_o), .rchk_o (rchk_o),
        .alert_major_o (alert_major_o), .alert_minor_o (alert_minor_o),
        .proto_errs_o (proto_errs), .data_errs_o (data_errs), .alert_errs_o (alert_errs),
        .pending_o (pending)
    );

    function automatic logic [`OBI_ACHK_WIDTH-1:0] make_achk(input obi_mem_pkg::obi_req_t p);
        logic [`OBI_ACHK_WIDTH-1:0] c;
        for (int i = 0; i < 4; i++) begin
            c[i]     = ^p.addr[8*i +: 8];
            c[4 + i] = ^p.wdata[8*i +: 8];
        end
        c[8] = ^{p.we, p.be};
        return c;
    endfunction

    // One request slot, driven after a falling edge
    task automatic drive_slot(input logic corrupt);
        logic [31:0]           r;
        logic [31:0]           r2;
        obi_mem_pkg::obi_req_t p;
        int                    k;
        r  = $random(seed);
        r2 = $random(seed);
        // Mostly a small window of words, so reads hit earlier writes
        if (r2[3:0] == 4'd0) begin
            p.addr = {r2[31:11], 1'b1, 10'd0};
        end else begin
            p.addr = {25'd0, r2[8:4], 2'b00};
        end
        p.we    = r[2];
        p.be    = r[7:4];
        p.wdata = $random(seed);
        p.achk  = make_achk(p);
        @(negedge clk);
        req_i    = (r[1:0] != 2'b00);
        reqpar_i = ~req_i;
        if (corrupt && r[12:10] == 3'd0) begin
            k = int'(r[27:24]) % `OBI_ACHK_WIDTH;
            p.achk[k] = ~p.achk[k];
        end else if (corrupt && r[12:10] == 3'd1) begin
            reqpar_i = req_i;
        end
        req_pld_i = p;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed      = 32'hf69d_d15d;
        reset_i   = 1'b1;
        req_i     = 1'b0;
        reqpar_i  = 1'b1;
        req_pld_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        for (int i = 0; i < NUM_CLEAN; i++) begin
            drive_slot(1'b0);
        end
        // Integrity faults only at the end, the major alert is sticky
        for (int i = 0; i < NUM_CORRUPT; i++) begin
            drive_slot(1'b1);
        end
        @(negedge clk);
        req_i    = 1'b0;
        reqpar_i = 1'b1;
        while (pending != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("Checks done: %0d protocol errors, %0d data errors, %0d alert errors",
                 proto_errs, data_errs, alert_errs);
        if (proto_errs + data_errs + alert_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/obi_mem_array.sv */
`timescale 1ns/10ps
`default_nettype none
`include "obi_mem_config.svh"

module obi_mem_array (
    input  logic                    clk_i,
    input  obi_mem_pkg::obi_stage_t stage_i,
    output obi_mem_pkg::obi_rsp_t   rsp_o
);

    // Word storage, contents survive reset
    logic [`OBI_DATA_WIDTH-1:0] mem_q [`OBI_MEM_WORDS];
    logic                       access_ok;
    logic                       do_write;
    logic                       do_read;
    obi_mem_pkg::obi_rsp_t      rsp_q;

    // --------------------------------------------------
    // Access decode
    // --------------------------------------------------
    // Faulted requests never touch the array
    assign access_ok = stage_i.valid && (stage_i.kind == obi_mem_pkg::RSP_OK);
    assign do_write  = access_ok && (stage_i.op == obi_mem_pkg::OP_WRITE);
    assign do_read   = access_ok && (stage_i.op == obi_mem_pkg::OP_READ);

    // --------------------------------------------------
    // Byte-enabled write
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (do_write) begin
            for (int b = 0; b < obi_mem_pkg::BE_WIDTH; b++) begin
                // Only enabled lanes are updated
                if (stage_i.be[b]) begin
                    mem_q[stage_i.word_idx][8*b +: 8] <= stage_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // Registered read and response
    // --------------------------------------------------
    // valid follows stage 1, which is cleared during reset
    always_ff @(posedge clk_i) begin
        rsp_q.valid <= stage_i.valid;
        rsp_q.kind  <= stage_i.kind;
        // Writes and faults return zero data
        if (do_read) begin
            rsp_q.rdata <= mem_q[stage_i.word_idx];
        end else begin
            rsp_q.rdata <= '0;
        end
    end

    assign rsp_o = rsp_q;

endmodule

`default_nettype wire

/* src/obi_mem_config.svh */
`ifndef OBI_MEM_CONFIG_SVH
`define OBI_MEM_CONFIG_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
// Byte address of the address phase
`define OBI_ADDR_WIDTH 32
// Read and write data
`define OBI_DATA_WIDTH 32

// --------------------------------------------------
// Integrity check widths
// --------------------------------------------------
// Four address byte parities, four wdata byte parities, one for we and be
`define OBI_ACHK_WIDTH 9
// Four rdata byte parities plus the err parity
`define OBI_RCHK_WIDTH 5

// Depth of the word array, which covers byte addresses 0 to 1023
`define OBI_MEM_WORDS 256

`endif

/* src/obi_mem_pkg.sv */
`default_nettype none
`include "obi_mem_config.svh"

package obi_mem_pkg;

    // --------------------------------------------------
    // Derived sizes
    // --------------------------------------------------
    // One byte enable per data byte
    localparam int BE_WIDTH = `OBI_DATA_WIDTH / 8;
    // Bits needed to index one word of the array
    localparam int WORD_IDX_WIDTH = $clog2(`OBI_MEM_WORDS);
    // First byte address past the end of the array
    localparam logic [`OBI_ADDR_WIDTH-1:0] MEM_BYTE_LIMIT = `OBI_MEM_WORDS * BE_WIDTH;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    // Outcome of the request check, carried down to the response
    typedef enum logic [1:0] {
        RSP_OK,
        RSP_ACHK_FAULT,
        RSP_RANGE_FAULT
    } rsp_kind_e;

    // --------------------------------------------------
    // Pipeline payloads
    // --------------------------------------------------
    // Address phase as it arrives at the top level
    typedef struct packed {
        logic [`OBI_ADDR_WIDTH-1:0] addr;
        logic                       we;
        logic [BE_WIDTH-1:0]        be;
        logic [`OBI_DATA_WIDTH-1:0] wdata;
        logic [`OBI_ACHK_WIDTH-1:0] achk;
    } obi_req_t;

    // Checked request, stage 1 to stage 2
    typedef struct packed {
        logic                      valid;
        mem_op_e                   op;
        logic [WORD_IDX_WIDTH-1:0] word_idx;
        logic [BE_WIDTH-1:0]       be;
        logic [`OBI_DATA_WIDTH-1:0] wdata;
        rsp_kind_e                 kind;
    } obi_stage_t;

    // Array result, stage 2 to stage 3
    typedef struct packed {
        logic                       valid;
        logic [`OBI_DATA_WIDTH-1:0] rdata;
        rsp_kind_e                  kind;
    } obi_rsp_t;

endpackage

`default_nettype wire

/* src/obi_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "obi_mem_config.svh"

module obi_mem_top (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Address phase
    input  logic                        req_i,
    input  logic                        reqpar_i,
    input  obi_mem_pkg::obi_req_t       req_pld_i,
    output logic                        gnt_o,
    output logic                        gntpar_o,
    // Response phase
    output logic                        rvalid_o,
    output logic                        rvalidpar_o,
    output logic [`OBI_DATA_WIDTH-1:0]  rdata_o,
    output logic                        err_o,
    output logic [`OBI_RCHK_WIDTH-1:0]  rchk_o,
    // Integrity alerts
    output logic                        alert_major_o,
    output logic                        alert_minor_o
);

    logic                    gnt;
    obi_mem_pkg::obi_stage_t stage;
    obi_mem_pkg::obi_rsp_t   rsp;

    // --------------------------------------------------
    // Stage 1, request check
    // --------------------------------------------------
    obi_req_checker i_req_checker (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .reqpar_i      (reqpar_i),
        .req_pld_i     (req_pld_i),
        .gnt_o         (gnt),
        .stage_o       (stage),
        .alert_major_o (alert_major_o)
    );

    // --------------------------------------------------
    // Stage 2, memory access
    // --------------------------------------------------
    obi_mem_array i_mem_array (
        .clk_i   (clk_i),
        .stage_i (stage),
        .rsp_o   (rsp)
    );

    // --------------------------------------------------
    // Stage 3, response encoding
    // --------------------------------------------------
    obi_rsp_encoder i_rsp_encoder (
        .rsp_i         (rsp),
        .rvalid_o      (rvalid_o),
        .rvalidpar_o   (rvalidpar_o),
        .rdata_o       (rdata_o),
        .err_o         (err_o),
        .rchk_o        (rchk_o),
        .alert_minor_o (alert_minor_o)
    );

    // Grant and its inverted copy
    assign gnt_o    = gnt;
    assign gntpar_o = ~gnt;

endmodule

`default_nettype wire

/* src/obi_req_checker.sv */
`timescale 1ns/10ps
`default_nettype none
`include "obi_mem_config.svh"

module obi_req_checker (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    req_i,
    input  logic                    reqpar_i,
    input  obi_mem_pkg::obi_req_t   req_pld_i,
    output logic                    gnt_o,
    output obi_mem_pkg::obi_stage_t stage_o,
    output logic                    alert_major_o
);

    // Bytes covered by each group of check bits
    localparam int ADDR_BYTES = `OBI_ADDR_WIDTH / 8;

    logic [`OBI_ACHK_WIDTH-1:0] achk_calc;
    logic                       accept;
    logic                       achk_bad;
    logic                       reqpar_bad;
    logic                       out_of_range;
    logic                       gnt_q;
    logic                       alert_major_q;
    obi_mem_pkg::obi_stage_t    stage_d;
    obi_mem_pkg::obi_stage_t    stage_q;

    // --------------------------------------------------
    // Integrity recompute
    // --------------------------------------------------
    always_comb begin
        achk_calc = '0;
        // Low nibble from the address bytes
        for (int i = 0; i < ADDR_BYTES; i++) begin
            achk_calc[i] = ^req_pld_i.addr[8*i +: 8];
        end
        // Next nibble from the write data bytes
        for (int i = 0; i < obi_mem_pkg::BE_WIDTH; i++) begin
            achk_calc[ADDR_BYTES+i] = ^req_pld_i.wdata[8*i +: 8];
        end
        // Top bit folds we with the byte enables
        achk_calc[`OBI_ACHK_WIDTH-1] = ^{req_pld_i.we, req_pld_i.be};
    end

    assign achk_bad     = (achk_calc != req_pld_i.achk);
    // reqpar is the inverted copy of req, checked every cycle
    assign reqpar_bad   = (reqpar_i == req_i);
    assign accept       = req_i && gnt_q;
    assign out_of_range = (req_pld_i.addr >= obi_mem_pkg::MEM_BYTE_LIMIT);

    // --------------------------------------------------
    // Classification
    // --------------------------------------------------
    always_comb begin
        stage_d.valid    = accept;
        stage_d.op       = req_pld_i.we ? obi_mem_pkg::OP_WRITE : obi_mem_pkg::OP_READ;
        // Word index drops the byte offset
        stage_d.word_idx = req_pld_i.addr[obi_mem_pkg::WORD_IDX_WIDTH+1:2];
        stage_d.be       = req_pld_i.be;
        stage_d.wdata    = req_pld_i.wdata;
        // Integrity fault wins over a range fault
        if (achk_bad) begin
            stage_d.kind = obi_mem_pkg::RSP_ACHK_FAULT;
        end else if (out_of_range) begin
            stage_d.kind = obi_mem_pkg::RSP_RANGE_FAULT;
        end else begin
            stage_d.kind = obi_mem_pkg::RSP_OK;
        end
    end

    // Stage register, only valid is cleared
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            stage_q.valid <= 1'b0;
        end else begin
            stage_q <= stage_d;
        end
    end

    // --------------------------------------------------
    // Grant and major alert
    // --------------------------------------------------
    // No back-pressure, grant rises after reset and stays up
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gnt_q <= 1'b0;
        end else begin
            gnt_q <= 1'b1;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            alert_major_q <= 1'b0;
        end else if (reqpar_bad || (accept && achk_bad)) begin
            alert_major_q <= 1'b1;
        end
    end

    assign gnt_o         = gnt_q;
    assign stage_o       = stage_q;
    assign alert_major_o = alert_major_q;

endmodule

`default_nettype wire

/* src/obi_rsp_encoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "obi_mem_config.svh"

module obi_rsp_encoder (
    input  obi_mem_pkg::obi_rsp_t       rsp_i,
    output logic                        rvalid_o,
    output logic                        rvalidpar_o,
    output logic [`OBI_DATA_WIDTH-1:0]  rdata_o,
    output logic                        err_o,
    output logic [`OBI_RCHK_WIDTH-1:0]  rchk_o,
    output logic                        alert_minor_o
);

    logic err;
    logic range_fault;

    // --------------------------------------------------
    // Response fields
    // --------------------------------------------------
    // rready is tied high, so the response is never held
    assign rvalid_o    = rsp_i.valid;
    // Inverted copy of rvalid
    assign rvalidpar_o = ~rsp_i.valid;
    assign rdata_o     = rsp_i.rdata;

    // Any fault kind is a bus error
    assign err         = rsp_i.valid && (rsp_i.kind != obi_mem_pkg::RSP_OK);
    assign err_o       = err;

    // --------------------------------------------------
    // Response check bits
    // --------------------------------------------------
    always_comb begin
        rchk_o = '0;
        // One even parity bit per rdata byte
        for (int i = 0; i < obi_mem_pkg::BE_WIDTH; i++) begin
            rchk_o[i] = ^rsp_i.rdata[8*i +: 8];
        end
        // Top bit covers err
        rchk_o[`OBI_RCHK_WIDTH-1] = err;
    end

    // --------------------------------------------------
    // Minor alert
    // --------------------------------------------------
    // Pulses with rvalid of an out-of-range response
    assign range_fault   = rsp_i.valid && (rsp_i.kind == obi_mem_pkg::RSP_RANGE_FAULT);
    assign alert_minor_o = range_fault;

endmodule

`default_nettype wire
